//--- include/audio_settings.svh
/* Audio playback settings
   Sample width, FIFO depth, clock ratios, frame slot and register map */

`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Channel width and FIFO depth (log2)
`define AUDIO_SAMPLE_W   24
`define AUDIO_FIFO_LG    4

// clk cycles per strobe
`define AUDIO_MCLK_DIV   4
`define AUDIO_SCLK_DIV   16

// sclk periods per channel slot
`define AUDIO_SLOT_BITS  32

// Register byte offsets
`define AUDIO_REG_CTRL   8'h00
`define AUDIO_REG_STATUS 8'h04
`define AUDIO_REG_THRESH 8'h08
`define AUDIO_REG_LEFT   8'h0C
`define AUDIO_REG_RIGHT  8'h10

`endif

//--- source/audio_pkg.sv
/* Audio playback types
   Stereo sample, Wishbone request/response, control and FIFO status */

`include "audio_settings.svh"

package audio_pkg;

    // FIFO level, one bit wider than the address
    typedef logic [`AUDIO_FIFO_LG:0] level_t;

    typedef logic [`AUDIO_SAMPLE_W-1:0] channel_t;

    typedef struct packed {
        channel_t left;
        channel_t right;
    } stereo_sample_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // soft_reset is a single cycle pulse
    typedef struct packed {
        logic   i2s_enable;
        logic   soft_reset;
        level_t threshold;
    } audio_ctrl_t;

    typedef struct packed {
        logic   full;
        logic   empty;
        level_t level;
    } fifo_status_t;

endpackage

//--- source/audio_clock_divider.sv
/* Audio clock divider
   One free-running counter issues the mclk and sclk enable strobes */

`include "audio_settings.svh"

module audio_clock_divider (
    input  logic clk,
    input  logic rst_n_i,
    output logic mclk_en_o,
    output logic sclk_en_o
);

    localparam int CNT_W  = $clog2(`AUDIO_SCLK_DIV);
    localparam int MCLK_W = $clog2(`AUDIO_MCLK_DIV);

    logic [CNT_W-1:0] cnt_q;
    logic             cnt_wrap;

    // Longest ratio sets the counter period
    assign cnt_wrap = (cnt_q == CNT_W'(`AUDIO_SCLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // mclk ratio divides the sclk ratio, so low bits give the faster strobe
    assign mclk_en_o = (cnt_q[MCLK_W-1:0] == MCLK_W'(`AUDIO_MCLK_DIV - 1));
    assign sclk_en_o = cnt_wrap;

endmodule

//--- source/sample_fifo.sv
/* Stereo sample FIFO
   Synchronous first-word-fall-through storage with full, empty and level */

`include "audio_settings.svh"

module sample_fifo (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      wr_i,
    input  logic                      rd_i,
    input  audio_pkg::stereo_sample_t data_i,
    output audio_pkg::stereo_sample_t data_o,
    output audio_pkg::fifo_status_t   status_o
);

    import audio_pkg::*;

    localparam int ADDR_W = `AUDIO_FIFO_LG;
    localparam int DEPTH  = 1 << ADDR_W;

    stereo_sample_t mem [DEPTH];

    // Pointers carry an extra wrap bit
    level_t wr_ptr_q;
    level_t rd_ptr_q;
    level_t level;
    logic   full;
    logic   empty;
    logic   do_wr;
    logic   do_rd;

    assign level = wr_ptr_q - rd_ptr_q;
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                   (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

    // Writes when full and reads when empty are dropped
    assign do_wr = wr_i && !full;
    assign do_rd = rd_i && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Head word is always presented
    assign data_o = mem[rd_ptr_q[ADDR_W-1:0]];

    assign status_o = '{full: full, empty: empty, level: level};

endmodule

//--- source/audio_wb_regs.sv
/* Audio register slave on Wishbone
   Control, status, threshold and sample registers, one-shot ack per access */

`include "audio_settings.svh"

module audio_wb_regs (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  audio_pkg::wb_req_t        wb_req_i,
    output audio_pkg::wb_rsp_t        wb_rsp_o,
    input  audio_pkg::fifo_status_t   fifo_status_i,
    input  logic                      fifo_low_i,
    input  logic                      underrun_i,
    output audio_pkg::audio_ctrl_t    ctrl_o,
    output audio_pkg::stereo_sample_t sample_o,
    output logic                      sample_wr_o
);

    import audio_pkg::*;

    localparam int LVL_W = `AUDIO_FIFO_LG + 1;

    logic           ack_q;
    logic           done_q;
    logic           access;
    logic           wr_en;
    logic [7:0]     offset;
    logic [31:0]    rd_data;
    logic [31:0]    rd_data_q;
    audio_ctrl_t    ctrl_q;
    channel_t       left_q;
    stereo_sample_t sample_q;
    logic           sample_wr_q;
    logic           overflow_q;
    logic           underrun_q;

    // New access only once stb has dropped after the last ack
    assign access = wb_req_i.stb && !ack_q && !done_q;
    assign wr_en  = access && wb_req_i.we;
    assign offset = wb_req_i.adr[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= access;
            done_q <= wb_req_i.stb && (done_q || ack_q);
        end
    end

    // Control and threshold, byte lane 0 only
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.soft_reset <= 1'b0;
            if (wr_en && wb_req_i.sel[0]) begin
                case (offset)
                    `AUDIO_REG_CTRL: begin
                        ctrl_q.i2s_enable <= wb_req_i.dat[0];
                        ctrl_q.soft_reset <= wb_req_i.dat[1];
                    end
                    `AUDIO_REG_THRESH: begin
                        ctrl_q.threshold <= wb_req_i.dat[LVL_W-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Left is held until the right write completes the pair
    always_ff @(posedge clk) begin
        if (wr_en && offset == `AUDIO_REG_LEFT) begin
            left_q <= wb_req_i.dat[`AUDIO_SAMPLE_W-1:0];
        end
        if (wr_en && offset == `AUDIO_REG_RIGHT) begin
            sample_q <= '{left: left_q, right: wb_req_i.dat[`AUDIO_SAMPLE_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sample_wr_q <= 1'b0;
        end else begin
            sample_wr_q <= wr_en && (offset == `AUDIO_REG_RIGHT);
        end
    end

    // Sticky error bits, cleared by any STATUS write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            overflow_q <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            if (wr_en && offset == `AUDIO_REG_STATUS) begin
                overflow_q <= 1'b0;
                underrun_q <= 1'b0;
            end
            if (sample_wr_q && fifo_status_i.full) begin
                overflow_q <= 1'b1;
            end
            if (underrun_i) begin
                underrun_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (offset)
            `AUDIO_REG_CTRL: rd_data[0] = ctrl_q.i2s_enable;
            `AUDIO_REG_STATUS: begin
                rd_data[0]            = fifo_status_i.full;
                rd_data[1]            = fifo_status_i.empty;
                rd_data[2]            = fifo_low_i;
                rd_data[3]            = overflow_q;
                rd_data[4]            = underrun_q;
                rd_data[8 +: LVL_W]   = fifo_status_i.level;
            end
            `AUDIO_REG_THRESH: rd_data[LVL_W-1:0] = ctrl_q.threshold;
            `AUDIO_REG_LEFT: rd_data[`AUDIO_SAMPLE_W-1:0] = left_q;
            default: rd_data = '0;
        endcase
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rd_data_q <= rd_data;
        end
    end

    assign wb_rsp_o    = '{dat: rd_data_q, ack: ack_q};
    assign ctrl_o      = ctrl_q;
    assign sample_o    = sample_q;
    assign sample_wr_o = sample_wr_q;

endmodule

//--- source/i2s_master.sv
/* I2S master
   Frame FSM that pops stereo samples and shifts them out MSB first */

`include "audio_settings.svh"

module i2s_master (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      enable_i,
    input  logic                      mclk_en_i,
    input  logic                      sclk_en_i,
    input  audio_pkg::stereo_sample_t sample_i,
    input  logic                      fifo_empty_i,
    output logic                      fifo_rd_o,
    output logic                      underrun_o,
    output logic                      mclk_o,
    output logic                      sclk_o,
    output logic                      lrclk_o,
    output logic                      sdata_o
);

    import audio_pkg::*;

    localparam int SLOT_W = `AUDIO_SLOT_BITS;
    localparam int CNT_W  = $clog2(SLOT_W);
    localparam int PAD_W  = SLOT_W - `AUDIO_SAMPLE_W;

    typedef enum logic [1:0] {IDLE, LOAD, LEFT, RIGHT} state_t;

    state_t         state_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [SLOT_W-1:0] shift_q;
    channel_t       right_q;
    stereo_sample_t word;
    logic           sclk_fall;
    logic           slot_end;

    assign sclk_fall = sclk_en_i && sclk_o;
    assign slot_end  = (bit_cnt_q == CNT_W'(SLOT_W - 1));

    // Empty FIFO at frame start sends a silent frame
    assign word       = fifo_empty_i ? '0 : sample_i;
    assign fifo_rd_o  = (state_q == LOAD) && !fifo_empty_i;
    assign underrun_o = (state_q == LOAD) && fifo_empty_i;

    // Bit clocks run only while enabled
    always_ff @(posedge clk) begin
        if (!rst_n_i || !enable_i) begin
            mclk_o <= 1'b0;
            sclk_o <= 1'b0;
        end else begin
            if (mclk_en_i) begin
                mclk_o <= !mclk_o;
            end
            if (sclk_en_i) begin
                sclk_o <= !sclk_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || !enable_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            lrclk_o   <= 1'b0;
            sdata_o   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (sclk_fall) begin
                        state_q   <= LOAD;
                        bit_cnt_q <= '0;
                        lrclk_o   <= 1'b0;
                        sdata_o   <= shift_q[SLOT_W-1];
                    end
                end
                LOAD: state_q <= LEFT;
                LEFT, RIGHT: begin
                    if (sclk_fall) begin
                        // Top bit trails lrclk by one sclk period
                        sdata_o <= shift_q[SLOT_W-1];
                        if (slot_end) begin
                            bit_cnt_q <= '0;
                            lrclk_o   <= (state_q == LEFT);
                            state_q   <= (state_q == LEFT) ? RIGHT : LOAD;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Slot shifter, channel data sits above the zero padding
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            shift_q <= '0;
        end else if (state_q == LOAD) begin
            shift_q <= {word.left, {PAD_W{1'b0}}};
            right_q <= word.right;
        end else if (sclk_fall) begin
            if (slot_end && state_q == LEFT) begin
                shift_q <= {right_q, {PAD_W{1'b0}}};
            end else begin
                shift_q <= shift_q << 1;
            end
        end
    end

endmodule

//--- source/audio_top.sv
/* Audio playback top level
   Wishbone registers feed the sample FIFO, drained by the I2S master */

module audio_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  audio_pkg::wb_req_t wb_req_i,
    output audio_pkg::wb_rsp_t wb_rsp_o,
    output logic               fifo_low_o,
    output logic               i2s_mclk_o,
    output logic               i2s_sclk_o,
    output logic               i2s_lrclk_o,
    output logic               i2s_sdata_o
);

    import audio_pkg::*;

    logic           dev_rst_n;
    logic           mclk_en;
    logic           sclk_en;
    logic           sample_wr;
    logic           fifo_rd;
    logic           underrun;
    logic           fifo_low;
    audio_ctrl_t    ctrl;
    fifo_status_t   fifo_status;
    stereo_sample_t sample_in;
    stereo_sample_t sample_head;

    // Soft reset clears the datapath but leaves the registers alone
    assign dev_rst_n = rst_n_i && !ctrl.soft_reset;

    // Interrupt source
    assign fifo_low   = (fifo_status.level < ctrl.threshold);
    assign fifo_low_o = fifo_low;

    audio_clock_divider clk_div (
        .clk       (clk),
        .rst_n_i   (dev_rst_n),
        .mclk_en_o (mclk_en),
        .sclk_en_o (sclk_en)
    );

    sample_fifo fifo (
        .clk      (clk),
        .rst_n_i  (dev_rst_n),
        .wr_i     (sample_wr),
        .rd_i     (fifo_rd),
        .data_i   (sample_in),
        .data_o   (sample_head),
        .status_o (fifo_status)
    );

    audio_wb_regs regs (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .fifo_status_i (fifo_status),
        .fifo_low_i    (fifo_low),
        .underrun_i    (underrun),
        .ctrl_o        (ctrl),
        .sample_o      (sample_in),
        .sample_wr_o   (sample_wr)
    );

    i2s_master i2s (
        .clk          (clk),
        .rst_n_i      (dev_rst_n),
        .enable_i     (ctrl.i2s_enable),
        .mclk_en_i    (mclk_en),
        .sclk_en_i    (sclk_en),
        .sample_i     (sample_head),
        .fifo_empty_i (fifo_status.empty),
        .fifo_rd_o    (fifo_rd),
        .underrun_o   (underrun),
        .mclk_o       (i2s_mclk_o),
        .sclk_o       (i2s_sclk_o),
        .lrclk_o      (i2s_lrclk_o),
        .sdata_o      (i2s_sdata_o)
    );

endmodule

//--- dv/audio_tb.sv
/* Audio playback testbench
   Runs bus commands from the stimulus file and decodes the I2S frames */

module audio_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    fifo_low_o;
    logic    i2s_mclk_o;
    logic    i2s_sclk_o;
    logic    i2s_lrclk_o;
    logic    i2s_sdata_o;

    logic [7:0]  op_mem [64];
    logic [31:0] a_mem [64];
    logic [31:0] b_mem [64];
    logic [31:0] c_mem [64];
    logic [47:0] frames_q [$];
    int          n_cmds = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    // Monitor state
    logic        sclk_q = 1'b0;
    logic        mclk_q = 1'b0;
    logic        prev_lr = 1'b0;
    logic [31:0] hist = '0;
    logic [23:0] left_word = '0;
    int          idle_cnt = 0;
    int          mclk_rises = 0;

    audio_top uut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .fifo_low_o  (fifo_low_o),
        .i2s_mclk_o  (i2s_mclk_o),
        .i2s_sclk_o  (i2s_sclk_o),
        .i2s_lrclk_o (i2s_lrclk_o),
        .i2s_sdata_o (i2s_sdata_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("[ERROR] %0t timeout, the I2S frames did not arrive in time", $time);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // Slot bits are delay, 24 data bits, then padding
    always @(posedge clk) begin
        idle_cnt = idle_cnt + 1;
        if (idle_cnt > 48) begin
            prev_lr = 1'b0;
        end
        if (i2s_mclk_o && !mclk_q) begin
            mclk_rises = mclk_rises + 1;
        end
        mclk_q = i2s_mclk_o;
        if (i2s_sclk_o && !sclk_q) begin
            // sclk period is 32 clk cycles and holds four mclk periods
            if (idle_cnt <= 48) begin
                check_value("i2s_sclk_o period", idle_cnt, 32);
                check_value("i2s_mclk_o rises", mclk_rises, 4);
            end
            mclk_rises = 0;
            idle_cnt = 0;
            if (i2s_lrclk_o != prev_lr) begin
                if (!prev_lr) begin
                    left_word = hist[30:7];
                end else begin
                    frames_q.push_back({left_word, hist[30:7]});
                end
            end
            hist = {hist[30:0], i2s_sdata_o};
            prev_lr = i2s_lrclk_o;
        end
        sclk_q = i2s_sclk_o;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, output logic [31:0] rdat);
        @(posedge clk);
        wb_req <= '{adr: adr, dat: dat, sel: 4'hF, we: we, stb: 1'b1};
        do begin
            @(posedge clk);
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        wb_req.stb <= 1'b0;
        @(posedge clk);
        check_value("wb_rsp.ack", wb_rsp.ack, 1'b0);
    endtask

    task automatic next_frame(output logic [47:0] pair);
        while (frames_q.size() == 0) begin
            @(posedge clk);
        end
        pair = frames_q.pop_front();
    endtask

    function automatic logic [23:0] swap_halves(input logic [23:0] v);
        return {v[11:0], v[23:12]};
    endfunction

    task automatic load_commands();
        int    fd;
        string line;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int    total = 0;
        fd = $fopen("dv/audio_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("RESULT: FAIL");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#" &&
                $sscanf(line, "%c %h %h %h", op, a, b, c) == 4) begin
                op_mem[n_cmds] = op;
                a_mem[n_cmds] = a;
                b_mem[n_cmds] = b;
                c_mem[n_cmds] = c;
                n_cmds++;
                if (op == "F" || op == "N") begin
                    total += a;
                end
            end
        end
        $fclose(fd);
        limit = (total + 4) * 2048;
    endtask

    initial begin
        logic [31:0] rdat;
        logic [47:0] pair;
        logic [23:0] left;
        logic        i2s_on;
        void'($urandom(19));
        i2s_on = 1'b0;
        wb_req = '0;
        load_commands();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("fifo_low_o", fifo_low_o, 1'b0);
        check_value("i2s_mclk_o", i2s_mclk_o, 1'b0);
        check_value("i2s_sclk_o", i2s_sclk_o, 1'b0);
        check_value("i2s_lrclk_o", i2s_lrclk_o, 1'b0);
        check_value("i2s_sdata_o", i2s_sdata_o, 1'b0);
        for (int k = 0; k < n_cmds; k++) begin
            repeat ($urandom % 4) @(posedge clk);
            case (op_mem[k])
                "W": begin
                    bus_access(1'b1, a_mem[k], b_mem[k], rdat);
                    if (a_mem[k] == 0) begin
                        i2s_on = b_mem[k][0];
                    end
                end
                "R": begin
                    bus_access(1'b0, a_mem[k], 32'h0, rdat);
                    check_value("wb_rsp.dat", rdat, b_mem[k]);
                    if (a_mem[k] == 32'h4 && !i2s_on) begin
                        check_value("fifo_low_o", fifo_low_o, b_mem[k][2]);
                    end
                end
                "P": begin
                    for (int i = 0; i < a_mem[k]; i++) begin
                        left = 24'(b_mem[k] + i * c_mem[k]);
                        bus_access(1'b1, 32'h0C, {8'h0, left}, rdat);
                        bus_access(1'b1, 32'h10, {8'h0, swap_halves(left)}, rdat);
                    end
                end
                "F": begin
                    for (int i = 0; i < a_mem[k]; i++) begin
                        left = 24'(b_mem[k] + i * c_mem[k]);
                        next_frame(pair);
                        check_value("i2s left", pair[47:24], left);
                        check_value("i2s right", pair[23:0], swap_halves(left));
                    end
                end
                "N": begin
                    frames_q.delete();
                    for (int i = 0; i < a_mem[k]; i++) begin
                        next_frame(pair);
                    end
                end
                default: check_value("stimulus op", op_mem[k], "W");
            endcase
        end
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/audio_pkg.sv
source/audio_clock_divider.sv
source/sample_fifo.sv
source/audio_wb_regs.sv
source/i2s_master.sv
source/audio_top.sv
dv/audio_tb.sv

//--- dv/audio_stimulus.txt
# op a b c, all hex: W adr dat, R adr expected, P count base step (push pairs),
# F count base step (expected frames), N count (skip frames); right = left with halves swapped
R 04 00000002 0
R 00 00000000 0
R 08 00000000 0
P 6 A00001 1
R 04 00000600 0
W 00 00000001 0
F 6 A00001 1
F 1 0 0
W 00 00000000 0
R 04 00000012 0
W 04 00000000 0
R 04 00000002 0
W 08 00000005 0
R 08 00000005 0
P 3 B00001 1
R 04 00000304 0
W 00 00000001 0
F 1 B00001 1
W 00 00000000 0
R 04 00000104 0
P 5 B00010 1
R 04 00000600 0
W 00 00000002 0
R 04 00000006 0
R 08 00000005 0
R 00 00000000 0
W 00 00000001 0
N 0 0 0
F 2 0 0
W 00 00000000 0
R 04 00000016 0
W 04 00000000 0
P 11 C00001 1
R 04 00001009 0
W 00 00000001 0
F 10 C00001 1
F 1 0 0
W 00 00000000 0
R 04 0000001E 0
W 04 00000000 0
R 04 00000006 0
R 00 00000000 0
